// ==== common/glb_cfg_pkg.sv ====
/*
 * global buffer configuration chain definitions
 * widths, address field positions and the structs of the chain and leaf bus
 */
package glb_cfg_pkg;

    localparam int CFG_ADDR_WIDTH = 32;
    localparam int CFG_DATA_WIDTH = 32;

    // address split into tile select and register index
    localparam int TILE_SEL_LSB        = 8;
    localparam int TILE_SEL_ADDR_WIDTH = 4;
    localparam int REG_IDX_LSB         = 2;
    localparam int REG_IDX_WIDTH       = 6;

    // leaf decoder cycle codes
    localparam logic [1:0] LEAF_CYCLE_RD = 2'b10;
    localparam logic [1:0] LEAF_CYCLE_WR = 2'b00;

    // write request, west to east
    typedef struct packed {
        logic                      wr_en;
        logic                      wr_clk_en;
        logic [CFG_ADDR_WIDTH-1:0] wr_addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
    } cfg_wr_t;

    // read request, west to east
    typedef struct packed {
        logic                      rd_en;
        logic                      rd_clk_en;
        logic [CFG_ADDR_WIDTH-1:0] rd_addr;
    } cfg_rd_req_t;

    // read response, east to west
    typedef struct packed {
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      rd_data_valid;
    } cfg_rd_rsp_t;

    // router to register block
    typedef struct packed {
        logic [CFG_DATA_WIDTH-1:0] wr_data;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic                      block_sel;
        logic                      valid;
        logic                      wr_dvld;
        logic [1:0]                cycle;
    } leaf_req_t;

    // register block back to router
    typedef struct packed {
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      ack;
        logic                      nack;
    } leaf_rsp_t;

endpackage

// ==== glb_tile/glb_tile_cfg_regs.sv ====
/*
 * global buffer tile register block
 * leaf decoder slave, writes in the request cycle, ack or nack two cycles later
 */
`timescale 1ns/1ps

module glb_tile_cfg_regs #(
    parameter int NUM_REGS = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  glb_cfg_pkg::leaf_req_t leaf_req,
    output glb_cfg_pkg::leaf_rsp_t leaf_rsp
);

    localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

    logic [glb_cfg_pkg::REG_IDX_WIDTH-1:0]  req_idx;
    logic                                   req_hit;
    logic                                   wr_fire;
    logic                                   rd_fire;
    logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] regs [NUM_REGS];

    // first read stage
    logic                                   rd_pend;
    logic                                   rd_hit;
    logic [IDX_W-1:0]                       rd_idx;

    // decode of the leaf request
    always_comb begin
        req_idx = leaf_req.addr[glb_cfg_pkg::REG_IDX_LSB +: glb_cfg_pkg::REG_IDX_WIDTH];
        req_hit = int'(req_idx) < NUM_REGS;
        wr_fire = leaf_req.valid & leaf_req.block_sel & leaf_req.wr_dvld;
        rd_fire = leaf_req.valid & leaf_req.block_sel &
                  (leaf_req.cycle == glb_cfg_pkg::LEAF_CYCLE_RD);
    end

    // register array, out of range writes are dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire && req_hit) begin
            regs[req_idx[IDX_W-1:0]] <= leaf_req.wr_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_pend <= 1'b0;
            rd_hit  <= 1'b0;
            rd_idx  <= '0;
        end else begin
            rd_pend <= rd_fire;
            rd_hit  <= req_hit;
            rd_idx  <= req_idx[IDX_W-1:0];
        end
    end

    // second stage drives the response
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leaf_rsp <= '0;
        end else begin
            leaf_rsp.ack  <= rd_pend & rd_hit;
            leaf_rsp.nack <= rd_pend & ~rd_hit;
            if (rd_pend && rd_hit) begin
                leaf_rsp.rd_data <= regs[rd_idx];
            end else begin
                leaf_rsp.rd_data <= '0;
            end
        end
    end

endmodule

// ==== glb_tile/glb_tile_cfg_ctrl.sv ====
/*
 * global buffer tile configuration router
 * claims requests addressed to this tile, forwards the rest east
 * and returns read responses west
 */
`timescale 1ns/1ps

module glb_tile_cfg_ctrl #(
    parameter int TILE_ID = 0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  glb_cfg_pkg::cfg_wr_t     wr_west,
    input  glb_cfg_pkg::cfg_rd_req_t rd_west,
    input  glb_cfg_pkg::cfg_rd_rsp_t rsp_east,
    input  glb_cfg_pkg::leaf_rsp_t   leaf_rsp,
    output glb_cfg_pkg::cfg_wr_t     wr_east,
    output glb_cfg_pkg::cfg_rd_req_t rd_east,
    output glb_cfg_pkg::cfg_rd_rsp_t rsp_west,
    output glb_cfg_pkg::leaf_req_t   leaf_req
);

    localparam logic [glb_cfg_pkg::TILE_SEL_ADDR_WIDTH-1:0] TILE_SEL =
        TILE_ID[glb_cfg_pkg::TILE_SEL_ADDR_WIDTH-1:0];

    logic                     wr_sel_match;
    logic                     rd_sel_match;
    logic                     rd_pend_d1;
    logic                     rd_pend_d2;
    glb_cfg_pkg::cfg_rd_rsp_t own_rsp;

    // tile select compare, independent of the strobes
    always_comb begin
        wr_sel_match = wr_west.wr_addr[glb_cfg_pkg::TILE_SEL_LSB +:
                                       glb_cfg_pkg::TILE_SEL_ADDR_WIDTH] == TILE_SEL;
        rd_sel_match = rd_west.rd_addr[glb_cfg_pkg::TILE_SEL_LSB +:
                                       glb_cfg_pkg::TILE_SEL_ADDR_WIDTH] == TILE_SEL;
    end

    // leaf request, read wins over write
    always_comb begin
        leaf_req = '0;
        if (rd_west.rd_en) begin
            leaf_req.addr      = rd_west.rd_addr;
            leaf_req.block_sel = rd_sel_match;
            leaf_req.valid     = 1'b1;
            leaf_req.wr_dvld   = 1'b0;
            leaf_req.cycle     = glb_cfg_pkg::LEAF_CYCLE_RD;
        end else if (wr_west.wr_en) begin
            leaf_req.wr_data   = wr_west.wr_data;
            leaf_req.addr      = wr_west.wr_addr;
            leaf_req.block_sel = wr_sel_match;
            leaf_req.valid     = 1'b1;
            leaf_req.wr_dvld   = 1'b1;
            leaf_req.cycle     = glb_cfg_pkg::LEAF_CYCLE_WR;
        end
    end

    // claimed reads, lined up with the leaf response two cycles later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_pend_d1 <= 1'b0;
            rd_pend_d2 <= 1'b0;
        end else begin
            rd_pend_d1 <= rd_west.rd_en & rd_sel_match;
            rd_pend_d2 <= rd_pend_d1;
        end
    end

    // capture of the local response
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            own_rsp <= '0;
        end else begin
            own_rsp.rd_data_valid <= rd_pend_d2 & (leaf_rsp.ack | leaf_rsp.nack);
            own_rsp.rd_data       <= rd_pend_d2 ? leaf_rsp.rd_data : '0;
        end
    end

    // write path east
    // the enable level itself always moves on so the next tile can follow it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_east <= '0;
        end else begin
            wr_east.wr_clk_en <= wr_west.wr_clk_en;
            if (wr_west.wr_clk_en) begin
                if (wr_west.wr_en && !wr_sel_match) begin
                    wr_east.wr_en   <= 1'b1;
                    wr_east.wr_addr <= wr_west.wr_addr;
                    wr_east.wr_data <= wr_west.wr_data;
                end else begin
                    wr_east.wr_en   <= 1'b0;
                    wr_east.wr_addr <= '0;
                    wr_east.wr_data <= '0;
                end
            end
        end
    end

    // read path east
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_east <= '0;
        end else begin
            rd_east.rd_clk_en <= rd_west.rd_clk_en;
            if (rd_west.rd_clk_en) begin
                if (rd_west.rd_en && !rd_sel_match) begin
                    rd_east.rd_en   <= 1'b1;
                    rd_east.rd_addr <= rd_west.rd_addr;
                end else begin
                    rd_east.rd_en   <= 1'b0;
                    rd_east.rd_addr <= '0;
                end
            end
        end
    end

    // response path west, own data ahead of east traffic
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_west <= '0;
        end else if (rd_west.rd_clk_en) begin
            if (own_rsp.rd_data_valid) begin
                rsp_west <= own_rsp;
            end else begin
                rsp_west <= rsp_east;
            end
        end
    end

endmodule

// ==== glb_tile/glb_tile.sv ====
/*
 * global buffer tile
 * configuration router plus its local register block
 */
`timescale 1ns/1ps

module glb_tile #(
    parameter int TILE_ID  = 0,
    parameter int NUM_REGS = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  glb_cfg_pkg::cfg_wr_t     wr_west,
    input  glb_cfg_pkg::cfg_rd_req_t rd_west,
    input  glb_cfg_pkg::cfg_rd_rsp_t rsp_east,
    output glb_cfg_pkg::cfg_wr_t     wr_east,
    output glb_cfg_pkg::cfg_rd_req_t rd_east,
    output glb_cfg_pkg::cfg_rd_rsp_t rsp_west
);

    glb_cfg_pkg::leaf_req_t leaf_req;
    glb_cfg_pkg::leaf_rsp_t leaf_rsp;

    glb_tile_cfg_ctrl #(
        .TILE_ID(TILE_ID)
    ) glb_tile_cfg_ctrl_inst (
        .clk      (clk),
        .reset    (reset),
        .wr_west  (wr_west),
        .rd_west  (rd_west),
        .rsp_east (rsp_east),
        .leaf_rsp (leaf_rsp),
        .wr_east  (wr_east),
        .rd_east  (rd_east),
        .rsp_west (rsp_west),
        .leaf_req (leaf_req)
    );

    glb_tile_cfg_regs #(
        .NUM_REGS(NUM_REGS)
    ) glb_tile_cfg_regs_inst (
        .clk      (clk),
        .reset    (reset),
        .leaf_req (leaf_req),
        .leaf_rsp (leaf_rsp)
    );

endmodule

// ==== src/glb_cfg_chain.sv ====
/*
 * global buffer configuration chain
 * row of tiles linked west to east, host on the west end
 */
`timescale 1ns/1ps

module glb_cfg_chain #(
    parameter int NUM_TILES = 4,
    parameter int NUM_REGS  = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  glb_cfg_pkg::cfg_wr_t     cfg_wr_in,
    input  glb_cfg_pkg::cfg_rd_req_t cfg_rd_in,
    output glb_cfg_pkg::cfg_rd_rsp_t cfg_rsp_out,
    output glb_cfg_pkg::cfg_wr_t     cfg_wr_out,
    output glb_cfg_pkg::cfg_rd_req_t cfg_rd_out
);

    // index i is the west side of tile i
    glb_cfg_pkg::cfg_wr_t     wr_link  [NUM_TILES+1];
    glb_cfg_pkg::cfg_rd_req_t rd_link  [NUM_TILES+1];
    glb_cfg_pkg::cfg_rd_rsp_t rsp_link [NUM_TILES+1];

    assign wr_link[0]          = cfg_wr_in;
    assign rd_link[0]          = cfg_rd_in;
    assign rsp_link[NUM_TILES] = '0;
    assign cfg_rsp_out         = rsp_link[0];
    assign cfg_wr_out          = wr_link[NUM_TILES];
    assign cfg_rd_out          = rd_link[NUM_TILES];

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        glb_tile #(
            .TILE_ID  (i),
            .NUM_REGS (NUM_REGS)
        ) glb_tile_inst (
            .clk      (clk),
            .reset    (reset),
            .wr_west  (wr_link[i]),
            .rd_west  (rd_link[i]),
            .rsp_east (rsp_link[i+1]),
            .wr_east  (wr_link[i+1]),
            .rd_east  (rd_link[i+1]),
            .rsp_west (rsp_link[i])
        );
    end

endmodule

// ==== test/glb_cfg_chain_props.sv ====
/*
 * bound checks for the configuration chain
 * compares the chain outputs with the values expected by the testbench
 */
`timescale 1ns/1ps

module glb_cfg_chain_props (
    input logic                     clk,
    input logic                     reset,
    input glb_cfg_pkg::cfg_rd_rsp_t cfg_rsp_out,
    input glb_cfg_pkg::cfg_wr_t     cfg_wr_out,
    input glb_cfg_pkg::cfg_rd_req_t cfg_rd_out
);

    // nothing leaves the chain before the host sends anything
    quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        !glb_cfg_chain_tb.req_seen |->
            !(cfg_rsp_out.rd_data_valid || cfg_wr_out.wr_en || cfg_rd_out.rd_en))
    else begin
        glb_cfg_chain_tb.assert_fails++;
        $error("[FAIL] %0t: outputs active after reset before any request", $time);
    end

    // response pulse lands in exactly the expected cycle
    rsp_strobe: assert property (@(posedge clk) disable iff (reset)
        cfg_rsp_out.rd_data_valid == glb_cfg_chain_tb.exp_rsp.rd_data_valid)
    else begin
        glb_cfg_chain_tb.assert_fails++;
        $error("[FAIL] %0t: rd_data_valid %b, expected %b", $time,
               $sampled(cfg_rsp_out.rd_data_valid),
               $sampled(glb_cfg_chain_tb.exp_rsp.rd_data_valid));
    end

    rsp_data: assert property (@(posedge clk) disable iff (reset)
        cfg_rsp_out.rd_data_valid |-> cfg_rsp_out.rd_data == glb_cfg_chain_tb.exp_rsp.rd_data)
    else begin
        glb_cfg_chain_tb.assert_fails++;
        $error("[FAIL] %0t: rd_data %h, expected %h", $time,
               $sampled(cfg_rsp_out.rd_data), $sampled(glb_cfg_chain_tb.exp_rsp.rd_data));
    end

    // claimed writes never reach the east end
    wr_east_strobe: assert property (@(posedge clk) disable iff (reset)
        cfg_wr_out.wr_en == glb_cfg_chain_tb.exp_wr.wr_en)
    else begin
        glb_cfg_chain_tb.assert_fails++;
        $error("[FAIL] %0t: east wr_en %b, expected %b", $time,
               $sampled(cfg_wr_out.wr_en), $sampled(glb_cfg_chain_tb.exp_wr.wr_en));
    end

    wr_east_fields: assert property (@(posedge clk) disable iff (reset)
        cfg_wr_out.wr_en |-> (cfg_wr_out.wr_addr == glb_cfg_chain_tb.exp_wr.wr_addr &&
                              cfg_wr_out.wr_data == glb_cfg_chain_tb.exp_wr.wr_data &&
                              cfg_wr_out.wr_clk_en == glb_cfg_chain_tb.exp_wr.wr_clk_en))
    else begin
        glb_cfg_chain_tb.assert_fails++;
        $error("[FAIL] %0t: east write %h/%h en %b, expected %h/%h en %b", $time,
               $sampled(cfg_wr_out.wr_addr), $sampled(cfg_wr_out.wr_data),
               $sampled(cfg_wr_out.wr_clk_en),
               $sampled(glb_cfg_chain_tb.exp_wr.wr_addr),
               $sampled(glb_cfg_chain_tb.exp_wr.wr_data),
               $sampled(glb_cfg_chain_tb.exp_wr.wr_clk_en));
    end

    rd_east_strobe: assert property (@(posedge clk) disable iff (reset)
        cfg_rd_out.rd_en == glb_cfg_chain_tb.exp_rd.rd_en)
    else begin
        glb_cfg_chain_tb.assert_fails++;
        $error("[FAIL] %0t: east rd_en %b, expected %b", $time,
               $sampled(cfg_rd_out.rd_en), $sampled(glb_cfg_chain_tb.exp_rd.rd_en));
    end

    rd_east_addr: assert property (@(posedge clk) disable iff (reset)
        cfg_rd_out.rd_en |-> (cfg_rd_out.rd_addr == glb_cfg_chain_tb.exp_rd.rd_addr &&
                              cfg_rd_out.rd_clk_en == glb_cfg_chain_tb.exp_rd.rd_clk_en))
    else begin
        glb_cfg_chain_tb.assert_fails++;
        $error("[FAIL] %0t: east rd_addr %h en %b, expected %h en %b", $time,
               $sampled(cfg_rd_out.rd_addr), $sampled(cfg_rd_out.rd_clk_en),
               $sampled(glb_cfg_chain_tb.exp_rd.rd_addr),
               $sampled(glb_cfg_chain_tb.exp_rd.rd_clk_en));
    end

endmodule

// ==== test/glb_cfg_chain_tb.sv ====
/*
 * testbench for the global buffer configuration chain
 * drives host writes and reads and keeps the expected outputs for the bound checks
 */
`timescale 1ns/1ps

module glb_cfg_chain_tb;

    localparam int NUM_TILES  = 4;
    localparam int NUM_REGS   = 8;
    localparam int DW         = glb_cfg_pkg::CFG_DATA_WIDTH;
    localparam int RSP_WINDOW = 2*NUM_TILES + 6;
    localparam int RD_CYCLES  = RSP_WINDOW + 2;
    localparam int TILE_REGS  = NUM_TILES*NUM_REGS;
    // reads and writes summed over all tests
    localparam int NUM_READS  = 3*NUM_TILES + 2*TILE_REGS + NUM_REGS + 4;
    localparam int NUM_WRITES = TILE_REGS + NUM_REGS + 6;
    localparam int WATCHDOG_CYCLES = NUM_READS*RD_CYCLES + NUM_WRITES*2 + 200;

    logic                     clk;
    logic                     reset;
    glb_cfg_pkg::cfg_wr_t     cfg_wr_in;
    glb_cfg_pkg::cfg_rd_req_t cfg_rd_in;
    glb_cfg_pkg::cfg_rd_rsp_t cfg_rsp_out;
    glb_cfg_pkg::cfg_wr_t     cfg_wr_out;
    glb_cfg_pkg::cfg_rd_req_t cfg_rd_out;

    // expected outputs of the current cycle
    glb_cfg_pkg::cfg_rd_rsp_t exp_rsp;
    glb_cfg_pkg::cfg_wr_t     exp_wr;
    glb_cfg_pkg::cfg_rd_req_t exp_rd;
    logic                     req_seen;

    logic [DW-1:0]            shadow [NUM_TILES][NUM_REGS];
    int                       rsp_due_q [$];
    logic [DW-1:0]            rsp_data_q [$];
    int                       wr_due_q [$];
    glb_cfg_pkg::cfg_wr_t     wr_exp_q [$];
    int                       rd_due_q [$];
    glb_cfg_pkg::cfg_rd_req_t rd_exp_q [$];

    int     cyc;
    integer seed;
    int     assert_fails;
    int     check_fails;
    int     errs_before;
    int     tests_run;
    int     tests_failed;

    glb_cfg_chain #(
        .NUM_TILES (NUM_TILES),
        .NUM_REGS  (NUM_REGS)
    ) glb_cfg_chain_inst (
        .clk         (clk),
        .reset       (reset),
        .cfg_wr_in   (cfg_wr_in),
        .cfg_rd_in   (cfg_rd_in),
        .cfg_rsp_out (cfg_rsp_out),
        .cfg_wr_out  (cfg_wr_out),
        .cfg_rd_out  (cfg_rd_out)
    );

    bind glb_cfg_chain glb_cfg_chain_props glb_cfg_chain_props_inst (
        .clk         (clk),
        .reset       (reset),
        .cfg_rsp_out (cfg_rsp_out),
        .cfg_wr_out  (cfg_wr_out),
        .cfg_rd_out  (cfg_rd_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected outputs for the cycle that starts at this edge
    always @(posedge clk) begin
        exp_rsp <= '0;
        exp_wr  <= '0;
        exp_rd  <= '0;
        if (reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
            if (rsp_due_q.size() > 0 && rsp_due_q[0] == cyc + 1) begin
                exp_rsp.rd_data_valid <= 1'b1;
                exp_rsp.rd_data       <= rsp_data_q.pop_front();
                void'(rsp_due_q.pop_front());
            end
            if (wr_due_q.size() > 0 && wr_due_q[0] == cyc + 1) begin
                exp_wr <= wr_exp_q.pop_front();
                void'(wr_due_q.pop_front());
            end
            if (rd_due_q.size() > 0 && rd_due_q[0] == cyc + 1) begin
                exp_rd <= rd_exp_q.pop_front();
                void'(rd_due_q.pop_front());
            end
        end
    end

    function automatic logic [31:0] make_addr(input int tile, input int idx);
        make_addr = (32'(tile) << glb_cfg_pkg::TILE_SEL_LSB) |
                    (32'(idx) << glb_cfg_pkg::REG_IDX_LSB);
    endfunction

    task automatic drive_write(input logic [31:0] addr, input logic [DW-1:0] data);
        int tile;
        int idx;
        tile = int'(addr[glb_cfg_pkg::TILE_SEL_LSB +: glb_cfg_pkg::TILE_SEL_ADDR_WIDTH]);
        idx  = int'(addr[glb_cfg_pkg::REG_IDX_LSB +: glb_cfg_pkg::REG_IDX_WIDTH]);
        @(posedge clk);
        cfg_wr_in.wr_en   <= 1'b1;
        cfg_wr_in.wr_addr <= addr;
        cfg_wr_in.wr_data <= data;
        req_seen          <= 1'b1;
        if (tile >= NUM_TILES) begin
            // unclaimed, one hop per tile to the east end
            wr_due_q.push_back(cyc + 1 + NUM_TILES);
            wr_exp_q.push_back('{wr_en: 1'b1, wr_clk_en: 1'b1, wr_addr: addr, wr_data: data});
        end else if (idx < NUM_REGS) begin
            shadow[tile][idx] = data;
        end
        @(posedge clk);
        cfg_wr_in.wr_en   <= 1'b0;
        cfg_wr_in.wr_addr <= '0;
        cfg_wr_in.wr_data <= '0;
    endtask

    task automatic read_and_wait(input logic [31:0] addr);
        int   tile;
        int   idx;
        int   waited;
        logic seen;
        tile   = int'(addr[glb_cfg_pkg::TILE_SEL_LSB +: glb_cfg_pkg::TILE_SEL_ADDR_WIDTH]);
        idx    = int'(addr[glb_cfg_pkg::REG_IDX_LSB +: glb_cfg_pkg::REG_IDX_WIDTH]);
        waited = 0;
        seen   = 1'b0;
        @(posedge clk);
        cfg_rd_in.rd_en   <= 1'b1;
        cfg_rd_in.rd_addr <= addr;
        req_seen          <= 1'b1;
        if (tile < NUM_TILES) begin
            // out and back, one hop per tile each way, plus the leaf latency
            rsp_due_q.push_back(cyc + 1 + 2*tile + 4);
            rsp_data_q.push_back((idx < NUM_REGS) ? shadow[tile][idx] : '0);
        end else begin
            rd_due_q.push_back(cyc + 1 + NUM_TILES);
            rd_exp_q.push_back('{rd_en: 1'b1, rd_clk_en: 1'b1, rd_addr: addr});
        end
        @(posedge clk);
        cfg_rd_in.rd_en   <= 1'b0;
        cfg_rd_in.rd_addr <= '0;
        while (!seen && waited < RSP_WINDOW) begin
            @(posedge clk);
            seen   = cfg_rsp_out.rd_data_valid;
            waited = waited + 1;
        end
        if (tile < NUM_TILES && !seen) begin
            check_fails++;
            $display("no read response from tile %0d within %0d cycles, at %0t",
                     tile, RSP_WINDOW, $time);
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        @(posedge clk);
        errs        = assert_fails + check_fails - errs_before;
        errs_before = assert_fails + check_fails;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        seed         = 32'hf86d;
        assert_fails = 0;
        check_fails  = 0;
        errs_before  = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        <= 1'b1;
        req_seen     <= 1'b0;
        cfg_wr_in    <= '{wr_en: 1'b0, wr_clk_en: 1'b1, wr_addr: '0, wr_data: '0};
        cfg_rd_in    <= '{rd_en: 1'b0, rd_clk_en: 1'b1, rd_addr: '0};
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                shadow[t][r] = '0;
            end
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        repeat (10) @(posedge clk);
        finish_test("idle after reset");

        for (int t = 0; t < NUM_TILES; t++) begin
            read_and_wait(make_addr(t, t));
            read_and_wait(make_addr(t, NUM_REGS - 1));
        end
        finish_test("unwritten registers");

        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                drive_write(make_addr(t, r), $random(seed));
            end
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                read_and_wait(make_addr(t, r));
            end
        end
        finish_test("write then read");

        // indexes past the register file alias low registers if decoded short
        for (int t = 0; t < NUM_TILES; t++) begin
            read_and_wait(make_addr(t, NUM_REGS + t));
        end
        drive_write(make_addr(1, NUM_REGS), $random(seed));
        drive_write(make_addr(1, (1 << glb_cfg_pkg::REG_IDX_WIDTH) - 1), $random(seed));
        for (int r = 0; r < NUM_REGS; r++) begin
            read_and_wait(make_addr(1, r));
        end
        finish_test("index out of range");

        for (int j = 0; j < 4; j++) begin
            drive_write(make_addr(NUM_TILES + 3*j, j) | ($random(seed) & 32'hffff_f003),
                        $random(seed));
            read_and_wait(make_addr(NUM_TILES + 3*j, j) | ($random(seed) & 32'hffff_f003));
        end
        repeat (NUM_TILES + 2) @(posedge clk);
        finish_test("pass through east");

        for (int r = 0; r < NUM_REGS; r++) begin
            drive_write(make_addr(2, r), $random(seed));
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                read_and_wait(make_addr(t, r));
            end
        end
        finish_test("tile isolation");

        $display("tests %0d, failed %0d, assertion errors %0d, other errors %0d",
                 tests_run, tests_failed, assert_fails, check_fails);
        if (assert_fails + check_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog sized from the read and write counts of all tests
    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== glb_cfg_chain.f ====
common/glb_cfg_pkg.sv
glb_tile/glb_tile_cfg_regs.sv
glb_tile/glb_tile_cfg_ctrl.sv
glb_tile/glb_tile.sv
src/glb_cfg_chain.sv
test/glb_cfg_chain_props.sv
test/glb_cfg_chain_tb.sv

// ==== Makefile ====
# Verilator build and run for the configuration chain

VERILATOR ?= verilator
TOP       ?= glb_cfg_chain_tb
LOG       ?= sim.log
FILELIST  ?= glb_cfg_chain.f
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation into $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "no verdict found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
